// ==== src/nn_pkg.sv ====
// nn package: fixed-point format, layer sizes and shared types
// for the fully connected layer
`default_nettype none

package nn_pkg;

    // Q8.8 fixed point
    localparam int WORD_W = 16;
    localparam int FRAC_W = 8;

    // previous layer height
    localparam int IN_COUNT = 3;
    // neurons in this layer
    localparam int OUT_COUNT = 4;
    // weights plus one bias per neuron row
    localparam int ROW_LEN = IN_COUNT + 1;
    localparam int ADDR_W = $clog2(ROW_LEN);

    // both FIFOs
    localparam int FIFO_DEPTH = 4;

    // row n holds w[n][0..2] then b[n], one hex word per line
    localparam string WEIGHT_FILE = "src/fc_weights.mem";

    // one activation, weight or bias
    typedef logic signed [WORD_W-1:0] word_t;

    // one layer result, act[n] from neuron n
    typedef struct packed {
        word_t [OUT_COUNT-1:0] act;
    } layer_vec_t;

endpackage

`default_nettype wire

// ==== src/sync_fifo.sv ====
// synchronous FIFO, circular buffer with first-word fall-through
// payload type set per instance
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
    import nn_pkg::*;
#(
    parameter type payload_t = word_t
) (
    input  wire logic     clk_i,
    input  wire logic     reset_i,
    input  wire logic     wr_en_i,
    input  payload_t      wr_data_i,
    input  wire logic     rd_en_i,
    output payload_t      rd_data_o,
    output logic          empty_o,
    output logic          full_o
);

    payload_t mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(FIFO_DEPTH+1)-1:0] count;
    logic wr_ok;
    logic rd_ok;

    assign empty_o = (count == 0);
    assign full_o  = (count == FIFO_DEPTH);

    // write while full / read while empty are dropped
    assign wr_ok = wr_en_i && !full_o;
    assign rd_ok = rd_en_i && !empty_o;

    // head visible without a read
    assign rd_data_o = mem[rd_ptr];

    // storage, no reset needed
    always_ff @(posedge clk_i) begin
        if (wr_ok) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                // wrap explicitly, depth need not be a power of two
                wr_ptr <= (wr_ptr == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            if (wr_ok && !rd_ok) begin
                count <= count + 1'b1;
            end else if (rd_ok && !wr_ok) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/fc_neuron.sv ====
// single neuron: weight row ROM and multiply-accumulate with bias add
// accumulates one input per sum strobe, bias on its own strobe
`timescale 1ns/1ps
`default_nettype none

module fc_neuron
    import nn_pkg::*;
#(
    parameter int NEURON_IDX = 0
) (
    input  wire logic              clk_i,
    input  wire logic              reset_i,
    input  word_t                  data_i,
    input  wire logic [ADDR_W-1:0] addr_i,
    input  wire logic              sum_en_i,
    input  wire logic              add_bias_i,
    input  wire logic              clear_i,
    output word_t                  data_o
);

    // whole table, this neuron only reads its own row
    word_t rom [OUT_COUNT*ROW_LEN];

    word_t weight;
    word_t bias;
    logic signed [2*WORD_W-1:0] product;
    logic signed [2*WORD_W-1:0] product_sh;
    word_t scaled;
    word_t acc;

    initial begin
        $readmemh(WEIGHT_FILE, rom);
    end

    // row select, weight by counter and bias at the row end
    assign weight = rom[NEURON_IDX*ROW_LEN + int'(addr_i)];
    assign bias   = rom[NEURON_IDX*ROW_LEN + IN_COUNT];

    // full width signed product
    assign product = data_i * weight;

    // back to Q8.8, arithmetic shift keeps the sign
    assign product_sh = product >>> FRAC_W;

    // truncate, upper bits dropped
    assign scaled = product_sh[WORD_W-1:0];

    // accumulator
    // sums wrap modulo 2^16, no saturation
    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            acc <= '0;
        end else if (add_bias_i) begin
            acc <= acc + bias;
        end else if (sum_en_i) begin
            acc <= acc + scaled;
        end
    end

    assign data_o = acc;

endmodule

`default_nettype wire

// ==== src/fc_layer.sv ====
// fully connected layer controller with the neuron array
// pops words from the input FIFO and hands out one result vector
`timescale 1ns/1ps
`default_nettype none

module fc_layer
    import nn_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  reset_i,

    // input FIFO side
    input  word_t      data_i,
    input  wire logic  empty_i,
    output logic       rd_en_o,

    // result side, valid/ready
    output logic       valid_o,
    input  wire logic  ready_i,
    output layer_vec_t data_o
);

    typedef enum logic [1:0] {
        ST_BUSY,
        ST_BIAS,
        ST_DONE
    } state_t;

    state_t state;
    state_t state_nxt;

    // weight address, shared by every neuron
    logic [ADDR_W-1:0] addr;
    logic last_word;

    logic sum_en;
    logic add_bias;
    logic clear;

    word_t neuron_out [OUT_COUNT];

    // pop only while collecting inputs
    assign rd_en_o = (state == ST_BUSY) && !empty_i;
    assign sum_en  = rd_en_o;

    // third word of the vector
    assign last_word = rd_en_o && (addr == ADDR_W'(IN_COUNT - 1));

    // bias cycle takes no input
    assign add_bias = (state == ST_BIAS);

    assign valid_o = (state == ST_DONE);

    // handshake clears the accumulators
    assign clear = valid_o && ready_i;

    // next state
    always_comb begin
        state_nxt = state;
        case (state)
            ST_BUSY: begin
                if (last_word) begin
                    state_nxt = ST_BIAS;
                end
            end
            ST_BIAS: begin
                state_nxt = ST_DONE;
            end
            ST_DONE: begin
                // hold result until the output FIFO takes it
                if (ready_i) begin
                    state_nxt = ST_BUSY;
                end
            end
            default: begin
                state_nxt = ST_BUSY;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= ST_BUSY;
        end else begin
            state <= state_nxt;
        end
    end

    // address counter, one step per consumed word
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            addr <= '0;
        end else if (last_word) begin
            addr <= '0;
        end else if (sum_en) begin
            addr <= addr + 1'b1;
        end
    end

    // neuron array, one row of the table each
    for (genvar i = 0; i < OUT_COUNT; i++) begin : g_neuron
        fc_neuron #(
            .NEURON_IDX(i)
        ) i_neuron (
            .clk_i      (clk_i),
            .reset_i    (reset_i),
            .data_i     (data_i),
            .addr_i     (addr),
            .sum_en_i   (sum_en),
            .add_bias_i (add_bias),
            .clear_i    (clear),
            .data_o     (neuron_out[i])
        );
    end

    // pack the accumulators into the result
    always_comb begin
        for (int n = 0; n < OUT_COUNT; n++) begin
            data_o.act[n] = neuron_out[n];
        end
    end

endmodule

`default_nettype wire

// ==== src/fc_layer_top.sv ====
// layer top: input word FIFO, fully connected layer, output vector FIFO
// valid/ready on both outer ports
`timescale 1ns/1ps
`default_nettype none

module fc_layer_top
    import nn_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  reset_i,
    input  wire logic  in_valid_i,
    input  word_t      in_data_i,
    output logic       in_ready_o,
    output logic       out_valid_o,
    output layer_vec_t out_data_o,
    input  wire logic  out_ready_i
);

    word_t      in_rd_data;
    logic       in_empty;
    logic       in_full;
    logic       in_rd_en;
    logic       layer_valid;
    logic       layer_ready;
    layer_vec_t layer_data;
    logic       out_empty;
    logic       out_full;

    // ready and valid from the FIFO flags
    assign in_ready_o  = !in_full;
    assign layer_ready = !out_full;
    assign out_valid_o = !out_empty;

    // input words, FIFO drops writes while full
    sync_fifo #(
        .payload_t(word_t)
    ) i_in_fifo (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .wr_en_i   (in_valid_i),
        .wr_data_i (in_data_i),
        .rd_en_i   (in_rd_en),
        .rd_data_o (in_rd_data),
        .empty_o   (in_empty),
        .full_o    (in_full)
    );

    fc_layer i_layer (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .data_i  (in_rd_data),
        .empty_i (in_empty),
        .rd_en_o (in_rd_en),
        .valid_o (layer_valid),
        .ready_i (layer_ready),
        .data_o  (layer_data)
    );

    // result vectors, popped by out_ready_i
    sync_fifo #(
        .payload_t(layer_vec_t)
    ) i_out_fifo (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .wr_en_i   (layer_valid),
        .wr_data_i (layer_data),
        .rd_en_i   (out_ready_i),
        .rd_data_o (out_data_o),
        .empty_o   (out_empty),
        .full_o    (out_full)
    );

endmodule

`default_nettype wire

// ==== verif/fc_layer_chk.sv ====
// layer top checker: FIFO overflow/underflow and result handshake
// attached to fc_layer_top by bind
`timescale 1ns/1ps
`default_nettype none

module fc_layer_chk
    import nn_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  reset_i,
    input  wire logic  in_valid_i,
    input  wire logic  in_full_i,
    input  wire logic  in_empty_i,
    input  wire logic  in_rd_en_i,
    input  wire logic  layer_valid_i,
    input  wire logic  layer_ready_i,
    input  layer_vec_t layer_data_i,
    input  wire logic  out_ready_i,
    input  wire logic  out_empty_i,
    input  wire logic  out_full_i,
    input  wire logic  out_valid_i
);

    // empty input FIFO stays empty without a push
    a_in_empty_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        (in_empty_i && !in_valid_i) |=> in_empty_i)
        else $error("input FIFO left empty without a write");

    // push into a full FIFO is dropped, count stays at depth
    a_in_full_drop: assert property (@(posedge clk_i) disable iff (reset_i)
        (in_full_i && in_valid_i && !in_rd_en_i) |=> in_full_i)
        else $error("input FIFO written while full");

    a_out_full_drop: assert property (@(posedge clk_i) disable iff (reset_i)
        (out_full_i && layer_valid_i && !out_ready_i) |=> out_full_i)
        else $error("output FIFO written while full");

    // pop of an empty FIFO must not wrap the count
    a_out_empty_read: assert property (@(posedge clk_i) disable iff (reset_i)
        (out_empty_i && out_ready_i && !layer_valid_i) |=> out_empty_i)
        else $error("output FIFO read while empty");

    // result held until taken
    a_valid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        (layer_valid_i && !layer_ready_i) |=> (layer_valid_i && $stable(layer_data_i)))
        else $error("layer result dropped or changed before ready");

    a_reset_out: assert property (@(posedge clk_i) reset_i |=> !out_valid_i)
        else $error("out_valid_o high right after reset");

endmodule

bind fc_layer_top fc_layer_chk i_chk (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .in_valid_i    (in_valid_i),
    .in_full_i     (in_full),
    .in_empty_i    (in_empty),
    .in_rd_en_i    (in_rd_en),
    .layer_valid_i (layer_valid),
    .layer_ready_i (layer_ready),
    .layer_data_i  (layer_data),
    .out_ready_i   (out_ready_i),
    .out_empty_i   (out_empty),
    .out_full_i    (out_full),
    .out_valid_i   (out_valid_o)
);

`default_nettype wire

// ==== verif/fc_layer_tb.sv ====
// layer top testbench: random vectors through the FIFOs, reference
// model of the Q8.8 layer and in-order scoreboard
`timescale 1ns/1ps
`default_nettype none

module fc_layer_tb
    import nn_pkg::*;
();

    // 61 vectors at well under 40 cycles each
    localparam int TIMEOUT_CYCLES = 3000;

    logic        clk_i;
    logic        reset_i;
    logic        in_valid_i;
    word_t       in_data_i;
    logic        in_ready_o;
    logic        out_valid_o;
    layer_vec_t  out_data_o;
    logic        out_ready_i;

    word_t       wtab [OUT_COUNT*ROW_LEN];
    layer_vec_t  exp_q [$];
    string       test_name;
    int          error_count;
    int          sent_count;
    int          checked_count;
    int          valid_pct;
    int          ready_pct;
    logic [31:0] in_rng;
    logic [31:0] out_rng;
    logic        saw_stall;

    fc_layer_top i_fc_layer_top (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .in_valid_i  (in_valid_i),
        .in_data_i   (in_data_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_data_o  (out_data_o),
        .out_ready_i (out_ready_i)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic bit in_chance(input int pct);
        in_rng = xorshift32(in_rng);
        return (in_rng % 100) < pct;
    endfunction

    function automatic word_t rand_word();
        in_rng = xorshift32(in_rng);
        return in_rng[15:0];
    endfunction

    // corner operands for the wrap test
    function automatic word_t extreme_word();
        in_rng = xorshift32(in_rng);
        case (in_rng[2:0])
            3'd0: return 16'h7fff;
            3'd1: return 16'h8000;
            3'd2: return 16'h8001;
            3'd3: return 16'hffff;
            3'd4: return 16'h0001;
            3'd5: return 16'h7f00;
            3'd6: return 16'hff00;
            default: return 16'h0100;
        endcase
    endfunction

    // expected result: 32-bit product, >>> 8, keep 16 bits, wrap, then bias
    function automatic layer_vec_t ref_layer(input word_t [IN_COUNT-1:0] x);
        layer_vec_t r;
        logic signed [31:0] xa;
        logic signed [31:0] wa;
        logic signed [31:0] p;
        logic [15:0] acc;
        for (int n = 0; n < OUT_COUNT; n++) begin
            acc = '0;
            for (int k = 0; k < IN_COUNT; k++) begin
                xa = x[k];
                wa = wtab[n*ROW_LEN + k];
                p = (xa * wa) >>> FRAC_W;
                acc = acc + p[15:0];
            end
            acc = acc + wtab[n*ROW_LEN + IN_COUNT];
            r.act[n] = acc;
        end
        return r;
    endfunction

    // present one word until the input FIFO takes it
    task automatic send_word(input word_t w);
        bit accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk_i);
            if (in_chance(valid_pct)) begin
                in_valid_i = 1'b1;
                in_data_i  = w;
                if (!in_ready_o) begin
                    saw_stall = 1'b1;
                end
                // in_ready_o is registered, stable until the next edge
                accepted = in_ready_o;
            end else begin
                in_valid_i = 1'b0;
                in_data_i  = rand_word();
            end
        end
    endtask

    task automatic send_vector(input word_t [IN_COUNT-1:0] x);
        for (int k = 0; k < IN_COUNT; k++) begin
            send_word(x[k]);
        end
        // third word accepted, result now owed
        exp_q.push_back(ref_layer(x));
        sent_count++;
    endtask

    task automatic drain();
        @(negedge clk_i);
        in_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
    endtask

    task automatic run_vectors(input string name, input int count, input bit extreme);
        word_t [IN_COUNT-1:0] x;
        test_name = name;
        for (int v = 0; v < count; v++) begin
            for (int k = 0; k < IN_COUNT; k++) begin
                x[k] = extreme ? extreme_word() : rand_word();
            end
            send_vector(x);
        end
        drain();
    endtask

    task automatic check_output(input layer_vec_t got);
        layer_vec_t exp;
        assert (exp_q.size() != 0) else begin
            error_count++;
            $display("ERROR: result %h came out in %s with no vector pending", got, test_name);
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            checked_count++;
            assert (got == exp) else begin
                error_count++;
                $display("FAIL %s: vector %0d expected %h actual %h",
                    test_name, checked_count, exp, got);
            end
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // output sink and compare, ready and sample on the falling edge
    initial begin
        out_ready_i = 1'b0;
        out_rng = 32'h0de4_6618 ^ 32'h9e37_79b9;
        forever begin
            @(negedge clk_i);
            out_rng = xorshift32(out_rng);
            out_ready_i = !reset_i && ((out_rng % 100) < ready_pct);
            if (out_valid_o && out_ready_i) begin
                check_output(out_data_o);
            end
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        error_count++;
        $display("ERROR: run did not finish in %0d cycles, %0d results still pending",
            TIMEOUT_CYCLES, exp_q.size());
        $display("checked %0d of %0d vectors, %0d errors", checked_count, sent_count, error_count);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        word_t [IN_COUNT-1:0] x;
        reset_i = 1'b1;
        in_valid_i = 1'b0;
        in_data_i = '0;
        in_rng = 32'h0de4_6618;
        valid_pct = 100;
        ready_pct = 100;
        saw_stall = 1'b0;
        error_count = 0;
        sent_count = 0;
        checked_count = 0;
        test_name = "reset";
        $readmemh(WEIGHT_FILE, wtab);
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        // 1.0, 0.5 and 2.0
        test_name = "single";
        x[0] = 16'h0100;
        x[1] = 16'h0080;
        x[2] = 16'h0200;
        assert (!out_valid_o) else begin
            error_count++;
            $display("ERROR: out_valid_o high before any input");
        end
        send_vector(x);
        drain();

        run_vectors("stream", 20, 1'b0);
        valid_pct = 50;
        run_vectors("input_gaps", 15, 1'b0);

        // slow sink backs up into the input FIFO
        valid_pct = 100;
        ready_pct = 30;
        saw_stall = 1'b0;
        run_vectors("backpressure", 15, 1'b0);
        assert (saw_stall) else begin
            error_count++;
            $display("ERROR: in_ready_o never dropped under output back-pressure");
        end

        ready_pct = 100;
        run_vectors("sign_wrap", 10, 1'b1);

        // nothing extra may show up after the last result
        repeat (20) @(negedge clk_i);
        assert (!out_valid_o && checked_count == sent_count) else begin
            error_count++;
            $display("ERROR: sent %0d vectors but checked %0d, out_valid_o %b",
                sent_count, checked_count, out_valid_o);
        end

        $display("checked %0d of %0d vectors, %0d errors", checked_count, sent_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/fc_weights.mem ====
// Q8.8 hex words, one per line, four lines per neuron row
// row order: w0 w1 w2 bias, neurons 0 to 3
0100
0080
ff00
0010
0200
ffc0
0040
ff80
fe80
0180
0100
0100
7fff
8000
0c00
0033

// ==== list.f ====
src/nn_pkg.sv
src/sync_fifo.sv
src/fc_neuron.sv
src/fc_layer.sv
src/fc_layer_top.sv
verif/fc_layer_chk.sv
verif/fc_layer_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the layer testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module fc_layer_tb \
    -f list.f -o fc_layer_sim || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/fc_layer_sim 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -qx "TB PASSED" && exit 0 || exit 1
